// ==== hdl/wisc_defs.svh ====
// Width macros for data word, register index, immediates, shift amount and call target
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// Datapath
`define WISC_WORD_W  16 // Data and PC width

// Register file index
`define WISC_REG_W   4  // Sixteen registers

// Instruction fields
`define WISC_IMM8_W  8  // LHB/LLB immediate
`define WISC_CALL_W  12 // Call target field
`define WISC_SHAMT_W 4  // Shift amount

`endif

// ==== hdl/wisc_pkg.sv ====
// Shared types of the execute stage: word, index, immediate, flag types and op enums
`default_nettype none
`include "wisc_defs.svh"

package wisc_pkg;

	typedef logic [`WISC_WORD_W-1:0]  word_t;     // Data or PC value
	typedef logic [`WISC_REG_W-1:0]   reg_idx_t;  // Destination register
	typedef logic [`WISC_IMM8_W-1:0]  imm8_t;     // Load-half immediate
	typedef logic [`WISC_CALL_W-1:0]  call_tgt_t; // Call target field
	typedef logic [`WISC_SHAMT_W-1:0] shamt_t;    // Shift amount
	typedef logic [2:0]               flags_t;    // {Z, V, N}

	// Bit positions inside flags_t
	localparam int flag_z = 2;
	localparam int flag_v = 1;
	localparam int flag_n = 0;

	typedef enum logic [2:0] {
		ADD  = 3'd0, // Saturating
		SUB  = 3'd1, // Saturating
		AND  = 3'd2,
		NOR  = 3'd3,
		SLL  = 3'd4,
		SRL  = 3'd5,
		SRA  = 3'd6,
		PADD = 3'd7  // Paired bytes, no carry between them
	} alu_op_e;

	typedef enum logic [2:0] {
		NEQ, EQ, GT, LT, GTE, LTE, OVFL, UNCOND
	} br_cond_e;

endpackage

`default_nettype wire

// ==== hdl/idex_reg.sv ====
// ID/EX pipeline register with reset control bits, stall hold and flush to bubble
`default_nettype none

module idex_reg import wisc_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      stall,          // Hold all contents
	input  wire logic      flush,          // Capture a bubble
	input  wire logic      reg_write_in,
	input  wire logic      mem_write_in,
	input  wire logic      mem_read_in,
	input  wire logic      mem_to_reg_in,
	input  wire logic      alu_src_in,
	input  wire logic      load_half_in,
	input  wire logic      half_spec_in,   // 0 LHB, 1 LLB
	input  wire logic      branch_in,
	input  wire logic      call_in,
	input  wire logic      ret_in,
	input  wire alu_op_e   alu_op_in,
	input  wire br_cond_e  br_cond_in,
	input  wire shamt_t    shift_in,
	input  wire imm8_t     imm_in,
	input  wire call_tgt_t call_target_in,
	input  wire word_t     rd_data_1_in,
	input  wire word_t     rd_data_2_in,
	input  wire word_t     sign_ext_in,
	input  wire reg_idx_t  reg_rd_in,
	input  wire word_t     pc_in,          // Next instruction address
	output logic           reg_write_q,
	output logic           mem_write_q,
	output logic           mem_read_q,
	output logic           mem_to_reg_q,
	output logic           alu_src_q,
	output logic           load_half_q,
	output logic           half_spec_q,
	output logic           branch_q,
	output logic           call_q,
	output logic           ret_q,
	output alu_op_e        alu_op_q,
	output br_cond_e       br_cond_q,
	output shamt_t         shift_q,
	output imm8_t          imm_q,
	output call_tgt_t      call_target_q,
	output word_t          rd_data_1_q,
	output word_t          rd_data_2_q,
	output word_t          sign_ext_q,
	output reg_idx_t       reg_rd_q,
	output word_t          pc_q
);

	localparam int ctrl_w = 10;

	logic [ctrl_w-1:0] ctrl_d; // Incoming controls, zero on flush
	logic [ctrl_w-1:0] ctrl_q;

	assign ctrl_d = flush ? '0 : {reg_write_in, mem_write_in, mem_read_in, mem_to_reg_in,
		alu_src_in, load_half_in, half_spec_in, branch_in, call_in, ret_in};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;        // No writes or redirects out of reset
		end else if (!stall) begin
			ctrl_q <= ctrl_d;    // Stall wins over flush
		end
	end

	assign {reg_write_q, mem_write_q, mem_read_q, mem_to_reg_q,
		alu_src_q, load_half_q, half_spec_q, branch_q, call_q, ret_q} = ctrl_q;

	// Payload kept on flush, only the controls turn into a bubble
	always_ff @(posedge clk) begin
		if (!stall) begin
			alu_op_q      <= alu_op_in;
			br_cond_q     <= br_cond_in;
			shift_q       <= shift_in;
			imm_q         <= imm_in;
			call_target_q <= call_target_in;
			rd_data_1_q   <= rd_data_1_in;
			rd_data_2_q   <= rd_data_2_in;
			sign_ext_q    <= sign_ext_in;
			reg_rd_q      <= reg_rd_in;
			pc_q          <= pc_in;
		end
	end

	// Decode never issues more than one PC-changing kind at once
	a_one_pc_op: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({branch_q, call_q, ret_q}))
		else $error("More than one of branch, call, ret in ID/EX");

	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable({ctrl_q, alu_op_q, br_cond_q, shift_q, imm_q, call_target_q,
			rd_data_1_q, rd_data_2_q, sign_ext_q, reg_rd_q, pc_q}))
		else $error("ID/EX contents moved under stall");

endmodule

`default_nettype wire

// ==== hdl/ex_alu.sv ====
// Execute ALU with operand select, saturating add/sub, shifts, load-half and Z/V/N flags
`default_nettype none
`include "wisc_defs.svh"

module ex_alu import wisc_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire logic    stall,      // Freezes the flags
	input  wire logic    reg_write,  // Low for a bubble
	input  wire alu_op_e alu_op,
	input  wire logic    alu_src,    // 1 selects sign_ext as B
	input  wire shamt_t  shift,
	input  wire logic    load_half,
	input  wire logic    half_spec,  // 0 LHB, 1 LLB
	input  wire imm8_t   imm,
	input  wire word_t   rd_data_1,  // Operand A, old dest for load-half
	input  wire word_t   rd_data_2,
	input  wire word_t   sign_ext,
	output word_t        result,
	output flags_t       flags       // {Z, V, N}
);

	localparam int w      = `WISC_WORD_W;
	localparam int half_w = `WISC_WORD_W / 2;

	word_t              op_b;       // Register or immediate
	logic [w:0]         sum_wide;   // Guard bit for overflow
	logic               ovfl;
	word_t              sum_sat;
	word_t              alu_out;
	word_t              half_merge;
	logic               flag_we;
	flags_t             flags_d;

	assign op_b = alu_src ? sign_ext : rd_data_2;

	// One adder for ADD and SUB, operands sign extended by one bit
	assign sum_wide = (alu_op == SUB) ? {rd_data_1[w-1], rd_data_1} - {op_b[w-1], op_b}
		: {rd_data_1[w-1], rd_data_1} + {op_b[w-1], op_b};
	assign ovfl     = sum_wide[w] ^ sum_wide[w-1]; // Guard and sign disagree

	// Clamp to the signed limit on the side of the true sign
	assign sum_sat = !ovfl ? sum_wide[w-1:0]
		: sum_wide[w] ? {1'b1, {(w-1){1'b0}}} : {1'b0, {(w-1){1'b1}}};

	always_comb begin
		case (alu_op)
			ADD, SUB: alu_out = sum_sat;
			AND:      alu_out = rd_data_1 & op_b;
			NOR:      alu_out = ~(rd_data_1 | op_b);
			SLL:      alu_out = rd_data_1 << shift;
			SRL:      alu_out = rd_data_1 >> shift;
			SRA:      alu_out = word_t'($signed(rd_data_1) >>> shift);
			PADD:     alu_out = {rd_data_1[w-1:half_w] + op_b[w-1:half_w],
				rd_data_1[half_w-1:0] + op_b[half_w-1:0]}; // Byte carry dropped
			default:  alu_out = '0;
		endcase
	end

	// LHB replaces the high byte, LLB the low byte
	assign half_merge = half_spec ? {rd_data_1[w-1:half_w], imm} : {imm, rd_data_1[half_w-1:0]};
	assign result     = load_half ? half_merge : alu_out;

	assign flag_we = !stall && reg_write && !load_half && (alu_op inside {ADD, SUB, AND, NOR});

	always_comb begin
		flags_d         = flags;                // Logic ops keep V and N
		flags_d[flag_z] = (result == '0);
		if (alu_op == ADD || alu_op == SUB) begin
			flags_d[flag_v] = ovfl;
			flags_d[flag_n] = result[w-1];      // Sign after saturation
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (flag_we) begin
			flags <= flags_d;
		end
	end

	a_logic_keeps_v: assert property (@(posedge clk) disable iff (!rst_n)
		flag_we && (alu_op inside {AND, NOR}) |=> flags[flag_v] == $past(flags[flag_v]))
		else $error("V changed on an AND/NOR flag update");

endmodule

`default_nettype wire

// ==== hdl/pc_redirect.sv ====
// Branch condition test and redirect target for branch, call and return
`default_nettype none
`include "wisc_defs.svh"

module pc_redirect import wisc_pkg::*; (
	input  wire logic      branch,
	input  wire logic      call,
	input  wire logic      ret,
	input  wire br_cond_e  br_cond,
	input  wire flags_t    flags,        // {Z, V, N} from the ALU
	input  wire word_t     pc,           // Already the next address
	input  wire word_t     sign_ext,     // Branch offset
	input  wire word_t     rd_data_1,    // Return address
	input  wire call_tgt_t call_target,
	output logic           redirect,
	output word_t          redirect_pc
);

	localparam int w = `WISC_WORD_W;

	logic z;
	logic v;
	logic n;
	logic cond_met;

	assign z = flags[flag_z];
	assign v = flags[flag_v];
	assign n = flags[flag_n];

	always_comb begin
		case (br_cond)
			NEQ:     cond_met = !z;
			EQ:      cond_met = z;
			GT:      cond_met = !z && !n;
			LT:      cond_met = n;
			GTE:     cond_met = !n;
			LTE:     cond_met = z || n;
			OVFL:    cond_met = v;
			UNCOND:  cond_met = 1'b1;
			default: cond_met = 1'b0;   // Unknown condition never taken
		endcase
	end

	assign redirect = (branch && cond_met) || call || ret;

	// Target mux, only one of ret, call, branch is live at a time
	always_comb begin
		if (ret) begin
			redirect_pc = rd_data_1;
		end else if (call) begin
			redirect_pc = {pc[w-1:`WISC_CALL_W], call_target}; // Stay in the 4K page
		end else begin
			redirect_pc = pc + sign_ext;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/wisc_ex_top.sv ====
// Execute stage top: ID/EX register, ALU with flags and PC redirect, flush fed back
`default_nettype none

module wisc_ex_top import wisc_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      stall,
	input  wire logic      reg_write_in,
	input  wire logic      mem_write_in,
	input  wire logic      mem_read_in,
	input  wire logic      mem_to_reg_in,
	input  wire logic      alu_src_in,
	input  wire logic      load_half_in,
	input  wire logic      half_spec_in,
	input  wire logic      branch_in,
	input  wire logic      call_in,
	input  wire logic      ret_in,
	input  wire alu_op_e   alu_op_in,
	input  wire br_cond_e  br_cond_in,
	input  wire shamt_t    shift_in,
	input  wire imm8_t     imm_in,
	input  wire call_tgt_t call_target_in,
	input  wire word_t     rd_data_1_in,
	input  wire word_t     rd_data_2_in,
	input  wire word_t     sign_ext_in,
	input  wire reg_idx_t  reg_rd_in,
	input  wire word_t     pc_in,
	output word_t          result,
	output word_t          store_data,   // Registered rd_data_2 for SW
	output reg_idx_t       reg_rd,
	output logic           reg_write,
	output logic           mem_write,
	output logic           mem_read,
	output logic           mem_to_reg,
	output logic           redirect,     // Also flushes the next capture
	output word_t          redirect_pc
);

	logic      alu_src_q;
	logic      load_half_q;
	logic      half_spec_q;
	logic      branch_q;
	logic      call_q;
	logic      ret_q;
	alu_op_e   alu_op_q;
	br_cond_e  br_cond_q;
	shamt_t    shift_q;
	imm8_t     imm_q;
	call_tgt_t call_target_q;
	word_t     rd_data_1_q;
	word_t     sign_ext_q;
	word_t     pc_q;
	flags_t    flags;           // ALU to redirect

	idex_reg idex_i (
		.clk, .rst_n, .stall,
		.flush (redirect),      // Kill the instruction behind a redirect
		.reg_write_in, .mem_write_in, .mem_read_in, .mem_to_reg_in, .alu_src_in,
		.load_half_in, .half_spec_in, .branch_in, .call_in, .ret_in,
		.alu_op_in, .br_cond_in, .shift_in, .imm_in, .call_target_in,
		.rd_data_1_in, .rd_data_2_in, .sign_ext_in, .reg_rd_in, .pc_in,
		.reg_write_q (reg_write), .mem_write_q (mem_write), .mem_read_q (mem_read),
		.mem_to_reg_q (mem_to_reg), .alu_src_q, .load_half_q, .half_spec_q,
		.branch_q, .call_q, .ret_q, .alu_op_q, .br_cond_q, .shift_q, .imm_q,
		.call_target_q, .rd_data_1_q, .rd_data_2_q (store_data), .sign_ext_q,
		.reg_rd_q (reg_rd), .pc_q
	);

	ex_alu alu_i (
		.clk, .rst_n, .stall, .reg_write,
		.alu_op (alu_op_q), .alu_src (alu_src_q), .shift (shift_q),
		.load_half (load_half_q), .half_spec (half_spec_q), .imm (imm_q),
		.rd_data_1 (rd_data_1_q), .rd_data_2 (store_data), .sign_ext (sign_ext_q),
		.result, .flags
	);

	pc_redirect redir_i (
		.branch (branch_q), .call (call_q), .ret (ret_q), .br_cond (br_cond_q),
		.flags, .pc (pc_q), .sign_ext (sign_ext_q), .rd_data_1 (rd_data_1_q),
		.call_target (call_target_q), .redirect, .redirect_pc
	);

endmodule

`default_nettype wire

// ==== dv/wisc_ex_tb.sv ====
// Execute stage testbench with clock, reset, xorshift stimulus, reference model and compare tasks
`default_nettype none
`include "wisc_defs.svh"

module wisc_ex_tb import wisc_pkg::*; ();

	typedef struct packed {
		logic      rw, mw, mr, m2r, src;  // Control bits cleared in a bubble
		logic      lh, hs, br, call, ret;
		alu_op_e   op;
		br_cond_e  cond;
		shamt_t    sh;
		imm8_t     imm;
		call_tgt_t ct;
		word_t     d1, d2, se;
		reg_idx_t  rd;
		word_t     pc;
	} instr_t;

	typedef struct packed {
		word_t  res;
		flags_t fl;     // Flags if this op updates them
		logic   redir;
		word_t  tgt;
	} exp_t;

	localparam int w    = `WISC_WORD_W;
	localparam int smax = 2 ** (w - 1) - 1;
	localparam int smin = -(2 ** (w - 1));

	logic        clk;
	logic        rst_n;
	logic        stall;
	instr_t      drv;           // Decode side ports
	instr_t      slot;          // Model of ID/EX contents
	flags_t      m_flags;       // Model of Z, V, N
	logic [31:0] rng;
	string       test_name;
	int          errors;
	int          checks;
	int          tests;
	int          mark;          // Error count at test start
	word_t       result, store_data, redirect_pc;
	reg_idx_t    reg_rd;
	logic        reg_write, mem_write, mem_read, mem_to_reg, redirect;
	word_t       setup_a [4] = '{16'd5, 16'd2, 16'd3, 16'h8000}; // Z, positive, N, V
	word_t       setup_b [4] = '{16'd5, 16'd3, 16'd9, 16'd1};
	alu_op_e     setup_op [4] = '{SUB, ADD, SUB, SUB};

	wisc_ex_top dut_i (
		.clk, .rst_n, .stall,
		.reg_write_in (drv.rw), .mem_write_in (drv.mw), .mem_read_in (drv.mr),
		.mem_to_reg_in (drv.m2r), .alu_src_in (drv.src), .load_half_in (drv.lh),
		.half_spec_in (drv.hs), .branch_in (drv.br), .call_in (drv.call), .ret_in (drv.ret),
		.alu_op_in (drv.op), .br_cond_in (drv.cond), .shift_in (drv.sh), .imm_in (drv.imm),
		.call_target_in (drv.ct), .rd_data_1_in (drv.d1), .rd_data_2_in (drv.d2),
		.sign_ext_in (drv.se), .reg_rd_in (drv.rd), .pc_in (drv.pc),
		.result, .store_data, .reg_rd, .reg_write, .mem_write, .mem_read, .mem_to_reg,
		.redirect, .redirect_pc
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rnd();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic instr_t bubble(input instr_t i);
		{i.rw, i.mw, i.mr, i.m2r, i.src} = '0;
		{i.lh, i.hs, i.br, i.call, i.ret} = '0;
		return i;
	endfunction

	// Random fields and memory controls with register write set
	function automatic instr_t alu_instr();
		logic [127:0] bits;
		instr_t       i;
		bits = {rnd(), rnd(), rnd(), rnd()};
		i    = instr_t'(bits[$bits(instr_t)-1:0]);
		{i.rw, i.lh, i.br, i.call, i.ret} = 5'b1_0000;
		return i;
	endfunction

	function automatic instr_t br_instr(input br_cond_e cond);
		instr_t i;
		i      = alu_instr();
		i.rw   = 1'b0;
		i.br   = 1'b1;
		i.cond = cond;
		return i;
	endfunction

	// Expected result, next flags and redirect of one instruction
	function automatic exp_t model_exec(input instr_t i, input flags_t f);
		exp_t  e;
		word_t b;
		int    a;
		int    bi;
		int    s;
		logic  taken;
		b    = i.src ? i.se : i.d2;
		a    = $signed(i.d1);
		bi   = $signed(b);
		e.fl = f;
		case (i.op)
			ADD, SUB: begin
				s = (i.op == ADD) ? a + bi : a - bi;
				e.fl[flag_v] = (s > smax) || (s < smin);
				e.res = (s > smax) ? word_t'(smax) : (s < smin) ? word_t'(smin) : word_t'(s);
			end
			AND:  e.res = i.d1 & b;
			NOR:  e.res = ~(i.d1 | b);
			SLL:  e.res = i.d1 << i.sh;
			SRL:  e.res = i.d1 >> i.sh;
			SRA:  e.res = word_t'($signed(i.d1) >>> i.sh);
			PADD: e.res = {i.d1[w-1:w/2] + b[w-1:w/2], i.d1[w/2-1:0] + b[w/2-1:0]};
		endcase
		if (i.lh) begin
			e.res = i.hs ? {i.d1[w-1:w/2], i.imm} : {i.imm, i.d1[w/2-1:0]};
		end
		e.fl[flag_z] = (e.res == '0);
		if (i.op == ADD || i.op == SUB) begin
			e.fl[flag_n] = e.res[w-1];
		end
		case (i.cond)
			NEQ:    taken = !f[flag_z];
			EQ:     taken = f[flag_z];
			GT:     taken = !f[flag_z] && !f[flag_n];
			LT:     taken = f[flag_n];
			GTE:    taken = !f[flag_n];
			LTE:    taken = f[flag_z] || f[flag_n];
			OVFL:   taken = f[flag_v];
			UNCOND: taken = 1'b1;
		endcase
		e.redir = (i.br && taken) || i.call || i.ret;
		e.tgt   = i.ret ? i.d1 : i.call ? {i.pc[w-1:`WISC_CALL_W], i.ct} : i.pc + i.se;
		return e;
	endfunction

	task automatic check_word(input string what, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_redirect(input logic exp_v, input word_t exp_pc,
		input logic act_v, input word_t act_pc);
		check_flag("redirect", exp_v, act_v);
		if (exp_v && act_v) begin
			check_word("redirect_pc", exp_pc, act_pc); // Target only matters when taken
		end
	endtask

	// Model state moves on the ID/EX edge and sees the pre-edge inputs
	always @(posedge clk) begin
		exp_t e;
		if (!rst_n) begin
			m_flags = '0;
			slot    = bubble(drv);
		end else if (!stall) begin
			e = model_exec(slot, m_flags);
			if (slot.rw && !slot.lh && (slot.op inside {ADD, SUB, AND, NOR})) begin
				m_flags = e.fl;
			end
			slot = e.redir ? bubble(drv) : drv; // Flush behind a redirect
		end
	end

	// Compare in the low phase once outputs settle
	always @(negedge clk) begin
		exp_t e;
		if (rst_n) begin
			e = model_exec(slot, m_flags);
			check_word("result", e.res, result);
			check_word("store_data", slot.d2, store_data);
			check_reg("reg_rd", slot.rd, reg_rd);
			check_flag("reg_write", slot.rw, reg_write);
			check_flag("mem_write", slot.mw, mem_write);
			check_flag("mem_read", slot.mr, mem_read);
			check_flag("mem_to_reg", slot.m2r, mem_to_reg);
			check_redirect(e.redir, e.tgt, redirect, redirect_pc);
		end
	end

	task automatic issue(input instr_t i, input logic hold);
		@(posedge clk);
		drv   <= i;
		stall <= hold;
	endtask

	task automatic wait_redirect();
		int n;
		n = 0;
		@(negedge clk);
		while (!redirect && n < 4) begin
			@(negedge clk);
			n++;
		end
		if (!redirect) begin
			errors++;
			$display("%s: redirect never went high after a call or return", test_name);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		mark      = errors;
	endtask

	task automatic end_test();
		repeat (2) @(posedge clk); // Last capture gets compared
		tests++;
		if (errors == mark) begin
			$display("test %s passed", test_name);
		end else begin
			$display("test %s had %0d errors", test_name, errors - mark);
		end
	endtask

	initial begin
		instr_t      i;
		logic [31:0] r;
		rng    = 32'd41;
		errors = 0;
		checks = 0;
		tests  = 0;
		rst_n <= 1'b0;
		stall <= 1'b0;
		drv   <= '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		start_test("reset");
		@(negedge clk);                                    // Nothing captured yet
		check_flag("reg_write", 1'b0, reg_write);
		check_flag("mem_write", 1'b0, mem_write);
		check_flag("mem_read", 1'b0, mem_read);
		check_flag("mem_to_reg", 1'b0, mem_to_reg);
		check_flag("redirect", 1'b0, redirect);
		end_test();

		start_test("alu_random");
		for (int k = 0; k < 200; k++) begin
			issue(alu_instr(), 1'b0);
		end
		end_test();

		start_test("load_half");
		i      = alu_instr();
		i.op   = ADD;
		i.src  = 1'b0;
		i.d1   = 16'h7000;
		i.d2   = 16'h7000;                                 // Saturates and sets V
		issue(i, 1'b0);
		for (int k = 0; k < 20; k++) begin
			i    = alu_instr();
			i.lh = 1'b1;
			issue(i, 1'b0);
		end
		issue(br_instr(OVFL), 1'b0);                       // V must have survived
		issue(alu_instr(), 1'b0);
		end_test();

		start_test("branch");
		for (int s = 0; s < 4; s++) begin
			for (int c = 0; c < 8; c++) begin
				i     = alu_instr();
				i.op  = setup_op[s];
				i.src = 1'b0;
				i.d1  = setup_a[s];
				i.d2  = setup_b[s];
				issue(i, 1'b0);
				issue(br_instr(br_cond_e'(c[2:0])), 1'b0);
				issue(alu_instr(), 1'b0);                  // Flushed if taken
			end
		end
		end_test();

		start_test("call_ret");
		for (int k = 0; k < 8; k++) begin
			i      = alu_instr();
			i.rw   = 1'b0;
			i.ret  = k[0];
			i.call = !k[0];
			issue(i, 1'b0);
			i = alu_instr();
			{i.mw, i.mr, i.m2r} = 3'b111;                  // Must come out as a bubble
			issue(i, 1'b0);
			wait_redirect();
		end
		end_test();

		start_test("stall");
		issue(br_instr(UNCOND), 1'b0);
		issue(alu_instr(), 1'b1);                          // Stall over a live flush
		issue(alu_instr(), 1'b1);
		issue(alu_instr(), 1'b0);
		for (int k = 0; k < 300; k++) begin
			r = rnd();
			i = (r[3:2] == 2'b00) ? br_instr(br_cond_e'(r[6:4])) : alu_instr();
			issue(i, r[1:0] == 2'b00);
		end
		issue(alu_instr(), 1'b0);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wisc_ex.f ====
+incdir+hdl
hdl/wisc_pkg.sv
hdl/idex_reg.sv
hdl/ex_alu.sv
hdl/pc_redirect.sv
hdl/wisc_ex_top.sv
dv/wisc_ex_tb.sv

// ==== Bender.yml ====
package:
  name: wisc_ex

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wisc_pkg.sv
      - hdl/idex_reg.sv
      - hdl/ex_alu.sv
      - hdl/pc_redirect.sv
      - hdl/wisc_ex_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/wisc_ex_tb.sv
